// ==== hw/bp_pkg.sv ====
// shared widths and types of the predictor; PCs are word aligned, so bits 1:0 never index a table
package bp_pkg;

    localparam int XLEN = 32;

    // the BTB is direct mapped and indexed by PC bits 6 down to 2
    localparam int BTB_ENTRIES = 32;
    localparam int BTB_IDX_W   = 5;

    // global history length, which also sets the PHT depth
    localparam int GHR_W       = 5;
    localparam int PHT_ENTRIES = 1 << GHR_W;

    typedef logic [XLEN-1:0]      addr_t;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [GHR_W-1:0]     pht_idx_t;
    typedef logic [1:0]           ctr_t;
    typedef logic [31:0]          reg_data_t;

    // a fresh counter is weakly-not-taken and one taken update flips it to taken
    localparam ctr_t PHT_RESET = 2'b01;

    // branch kind as handed over by the decoder, jal and jalr both map to BR_JUMP
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_COND = 2'd1,
        BR_JUMP = 2'd2
    } br_kind_t;

    // one resolved control transfer coming back from execute
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        addr_t    target;
        br_kind_t kind;
        logic     taken;
        // index returned by the lookup of this branch
        pht_idx_t pht_idx;
    } bp_update_t;

    // register map of the control block
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_GHR    = 2'd1;
    localparam logic [1:0] REG_NCOND  = 2'd2;
    localparam logic [1:0] REG_NTAKEN = 2'd3;

endpackage

// ==== hw/bp_btb.sv ====
// direct-mapped BTB with full-PC tags; lookup is combinational and writes show from the next cycle
`timescale 1ns/1ps

module bp_btb (
    input  logic               clk,
    input  logic               arst_n_i,
    input  bp_pkg::addr_t      lookup_pc_i,
    input  bp_pkg::bp_update_t update_i,
    input  logic               pht_taken_i,
    input  logic               enable_i,
    input  logic               flush_i,
    output logic               predict_taken_o,
    output bp_pkg::addr_t      predict_target_o
);

    bp_pkg::addr_t                  tag_q    [bp_pkg::BTB_ENTRIES];
    bp_pkg::addr_t                  target_q [bp_pkg::BTB_ENTRIES];
    logic [bp_pkg::BTB_ENTRIES-1:0] jump_q;
    logic [bp_pkg::BTB_ENTRIES-1:0] valid_q;

    bp_pkg::btb_idx_t lk_idx;
    bp_pkg::btb_idx_t up_idx;
    logic             hit;
    logic             btb_we;

    assign lk_idx = lookup_pc_i[bp_pkg::BTB_IDX_W+1:2];
    assign up_idx = update_i.pc[bp_pkg::BTB_IDX_W+1:2];

    // only taken transfers allocate, a not-taken branch would never redirect fetch
    assign btb_we = update_i.valid && update_i.taken &&
                    (update_i.kind == bp_pkg::BR_COND || update_i.kind == bp_pkg::BR_JUMP);

    assign hit = valid_q[lk_idx] && (tag_q[lk_idx] == lookup_pc_i);

    always_comb begin
        if (enable_i && hit) begin
            predict_taken_o  = jump_q[lk_idx] || pht_taken_i;
            predict_target_o = target_q[lk_idx];
        end else begin
            predict_taken_o  = 1'b0;
            predict_target_o = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            // a flush drops every entry, including one written in the same cycle
            valid_q <= '0;
        end else if (btb_we) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btb_we) begin
            tag_q[up_idx]    <= update_i.pc;
            target_q[up_idx] <= update_i.target;
            jump_q[up_idx]   <= (update_i.kind == bp_pkg::BR_JUMP);
        end
    end

    // a taken prediction must come from an entry that was allocated and not flushed
    a_taken_needs_valid : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        predict_taken_o |-> valid_q[lk_idx] && !$past(flush_i)
    );

    // the pipeline must never present unknown control or update fields
    a_flush_known : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$isunknown(flush_i) && !$isunknown(update_i.valid)
    );

    a_update_known : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        update_i.valid |-> !$isunknown(update_i)
    );

endmodule

// ==== hw/bp_gshare.sv ====
// gshare predictor; trains at the index handed back with the update, flush clears only the GHR
`timescale 1ns/1ps

module bp_gshare (
    input  logic               clk,
    input  logic               arst_n_i,
    input  bp_pkg::addr_t      lookup_pc_i,
    input  bp_pkg::bp_update_t update_i,
    input  logic               flush_i,
    output logic               pht_taken_o,
    output bp_pkg::pht_idx_t   pht_idx_o,
    output bp_pkg::pht_idx_t   ghr_o
);

    bp_pkg::ctr_t     pht_q [bp_pkg::PHT_ENTRIES];
    bp_pkg::pht_idx_t ghr_q;

    bp_pkg::pht_idx_t rd_idx;
    bp_pkg::ctr_t     upd_ctr;
    logic             cond_upd;

    // hash of the word address with the global history
    assign rd_idx = lookup_pc_i[bp_pkg::GHR_W+1:2] ^ ghr_q;

    assign pht_idx_o   = rd_idx;
    assign pht_taken_o = pht_q[rd_idx][1];
    assign ghr_o       = ghr_q;

    assign cond_upd = update_i.valid && (update_i.kind == bp_pkg::BR_COND);
    assign upd_ctr  = pht_q[update_i.pht_idx];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < bp_pkg::PHT_ENTRIES; i++) begin
                pht_q[i] <= bp_pkg::PHT_RESET;
            end
        end else if (cond_upd) begin
            if (update_i.taken && upd_ctr != 2'b11) begin
                pht_q[update_i.pht_idx] <= upd_ctr + 2'b01;
            end else if (!update_i.taken && upd_ctr != 2'b00) begin
                pht_q[update_i.pht_idx] <= upd_ctr - 2'b01;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ghr_q <= '0;
        end else if (flush_i) begin
            ghr_q <= '0;
        end else if (cond_upd) begin
            // newest outcome enters at the LSB
            ghr_q <= {ghr_q[bp_pkg::GHR_W-2:0], update_i.taken};
        end
    end

    // a taken step never lowers the counter and a not-taken step never raises it, so 3 and 0 hold
    a_pht_saturates : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        cond_upd |=>
            !$isunknown(pht_q[$past(update_i.pht_idx)]) &&
            ($past(update_i.taken) ?
                pht_q[$past(update_i.pht_idx)] >= $past(upd_ctr) :
                pht_q[$past(update_i.pht_idx)] <= $past(upd_ctr))
    );

endmodule

// ==== hw/bp_regs.sv ====
// control and statistics registers; flush follows its write by a cycle, counters wrap at 2^32
`timescale 1ns/1ps

module bp_regs (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               reg_we_i,
    input  logic [1:0]         reg_addr_i,
    input  bp_pkg::reg_data_t  reg_wdata_i,
    input  bp_pkg::bp_update_t update_i,
    input  bp_pkg::pht_idx_t   ghr_i,
    output bp_pkg::reg_data_t  reg_rdata_o,
    output logic               enable_o,
    output logic               flush_o
);

    logic              enable_q;
    logic              flush_q;
    bp_pkg::reg_data_t ncond_q;
    bp_pkg::reg_data_t ntaken_q;

    logic ctrl_we;
    logic cond_upd;

    assign ctrl_we  = reg_we_i && (reg_addr_i == bp_pkg::REG_CTRL);
    assign cond_upd = update_i.valid && (update_i.kind == bp_pkg::BR_COND);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q <= 1'b1;
            flush_q  <= 1'b0;
        end else begin
            if (ctrl_we) begin
                enable_q <= reg_wdata_i[0];
            end
            // bit 1 is a trigger, back to back writes still give a single pulse
            flush_q <= ctrl_we && reg_wdata_i[1] && !flush_q;
        end
    end

    // a write to either counter clears it, even when an update lands in the same cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ncond_q  <= '0;
            ntaken_q <= '0;
        end else begin
            if (reg_we_i && reg_addr_i == bp_pkg::REG_NCOND) begin
                ncond_q <= '0;
            end else if (cond_upd) begin
                ncond_q <= ncond_q + 32'd1;
            end
            if (reg_we_i && reg_addr_i == bp_pkg::REG_NTAKEN) begin
                ntaken_q <= '0;
            end else if (cond_upd && update_i.taken) begin
                ntaken_q <= ntaken_q + 32'd1;
            end
        end
    end

    always_comb begin
        case (reg_addr_i)
            bp_pkg::REG_CTRL:  reg_rdata_o = {31'b0, enable_q};
            bp_pkg::REG_GHR:   reg_rdata_o = {{(32 - bp_pkg::GHR_W){1'b0}}, ghr_i};
            bp_pkg::REG_NCOND: reg_rdata_o = ncond_q;
            default:           reg_rdata_o = ntaken_q;
        endcase
    end

    assign enable_o = enable_q;
    assign flush_o  = flush_q;

    a_flush_one_cycle : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        flush_o |=> !flush_o
    );

endmodule

// ==== hw/branch_predictor.sv ====
// predictor top; lookups are combinational and pht_idx_o must come back in update_i
`timescale 1ns/1ps

module branch_predictor (
    input  logic               clk,
    input  logic               arst_n_i,
    input  bp_pkg::addr_t      lookup_pc_i,
    input  bp_pkg::bp_update_t update_i,
    input  logic               reg_we_i,
    input  logic [1:0]         reg_addr_i,
    input  bp_pkg::reg_data_t  reg_wdata_i,
    output logic               predict_taken_o,
    output bp_pkg::addr_t      predict_target_o,
    output bp_pkg::pht_idx_t   pht_idx_o,
    output bp_pkg::reg_data_t  reg_rdata_o
);

    logic             enable;
    logic             flush;
    logic             pht_taken;
    bp_pkg::pht_idx_t ghr;

    bp_regs i_bp_regs (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .update_i    (update_i),
        .ghr_i       (ghr),
        .reg_rdata_o (reg_rdata_o),
        .enable_o    (enable),
        .flush_o     (flush)
    );

    bp_gshare i_bp_gshare (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .lookup_pc_i (lookup_pc_i),
        .update_i    (update_i),
        .flush_i     (flush),
        .pht_taken_o (pht_taken),
        .pht_idx_o   (pht_idx_o),
        .ghr_o       (ghr)
    );

    bp_btb i_bp_btb (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .lookup_pc_i      (lookup_pc_i),
        .update_i         (update_i),
        .pht_taken_i      (pht_taken),
        .enable_i         (enable),
        .flush_i          (flush),
        .predict_taken_o  (predict_taken_o),
        .predict_target_o (predict_target_o)
    );

endmodule

// ==== bench/tb_branch_predictor.sv ====
// self-checking testbench; PCs are word aligned and the PHT index is handed back as looked up
`timescale 1ns/1ps

module tb_branch_predictor;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 16;
    // reset, the directed tests and 400 random cycles, rounded up
    localparam int TEST_CYCLES   = 700;
    localparam int MARGIN_CYCLES = 100;

    localparam bp_pkg::addr_t    PC_A  = 32'h0000_1040;
    localparam bp_pkg::addr_t    PC_B  = 32'h0000_10c0;
    localparam bp_pkg::addr_t    PC_C  = 32'h0000_2008;
    localparam bp_pkg::addr_t    PC_Q  = 32'h0000_3050;
    localparam bp_pkg::pht_idx_t P_IDX = 5'd2;
    localparam bp_pkg::pht_idx_t Q_IDX = 5'd20;

    typedef struct packed {
        logic             taken;
        bp_pkg::addr_t    target;
        bp_pkg::pht_idx_t idx;
    } pred_t;

    logic               clk;
    logic               arst_n_i;
    bp_pkg::addr_t      lookup_pc;
    bp_pkg::bp_update_t upd;
    logic               reg_we;
    logic [1:0]         reg_addr;
    bp_pkg::reg_data_t  reg_wdata;
    logic               predict_taken;
    bp_pkg::addr_t      predict_target;
    bp_pkg::pht_idx_t   pht_idx;
    bp_pkg::reg_data_t  reg_rdata;

    // reference state, advanced once per rising edge with the inputs the DUT samples there
    logic [31:0]      m_valid;
    bp_pkg::addr_t    m_tag    [32];
    bp_pkg::addr_t    m_target [32];
    logic [31:0]      m_jump;
    bp_pkg::ctr_t     m_pht    [32];
    bp_pkg::pht_idx_t m_ghr;
    logic             m_enable;
    logic             m_flush;
    int unsigned      m_ncond;
    int unsigned      m_ntaken;

    logic check_en;
    int   n_checks;
    int   n_errors;

    branch_predictor i_branch_predictor (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .lookup_pc_i      (lookup_pc),
        .update_i         (upd),
        .reg_we_i         (reg_we),
        .reg_addr_i       (reg_addr),
        .reg_wdata_i      (reg_wdata),
        .predict_taken_o  (predict_taken),
        .predict_target_o (predict_target),
        .pht_idx_o        (pht_idx),
        .reg_rdata_o      (reg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic pred_t ref_predict(bp_pkg::addr_t pc);
        pred_t p;
        logic [4:0] bi;
        bi    = pc[6:2];
        p.idx = pc[6:2] ^ m_ghr;
        if (m_enable && m_valid[bi] && m_tag[bi] == pc) begin
            p.taken  = m_jump[bi] || m_pht[p.idx][1];
            p.target = m_target[bi];
        end else begin
            p.taken  = 1'b0;
            p.target = '0;
        end
        return p;
    endfunction

    function automatic bp_pkg::reg_data_t ref_read(logic [1:0] addr);
        case (addr)
            2'd0:    return {31'b0, m_enable};
            2'd1:    return {27'b0, m_ghr};
            2'd2:    return m_ncond;
            default: return m_ntaken;
        endcase
    endfunction

    task automatic model_commit();
        logic         flush_now;
        logic         ctrl_we;
        logic         cond;
        logic         btb_we;
        logic [4:0]   ui;
        bp_pkg::ctr_t c;
        flush_now = m_flush;
        ctrl_we   = reg_we && reg_addr == 2'd0;
        cond      = upd.valid && upd.kind == bp_pkg::BR_COND;
        btb_we    = upd.valid && upd.taken && upd.kind != bp_pkg::BR_NONE;
        ui        = upd.pc[6:2];
        if (btb_we) begin
            m_tag[ui]    = upd.pc;
            m_target[ui] = upd.target;
            m_jump[ui]   = (upd.kind == bp_pkg::BR_JUMP);
        end
        if (flush_now) begin
            m_valid = '0;
        end else if (btb_we) begin
            m_valid[ui] = 1'b1;
        end
        if (cond) begin
            c = m_pht[upd.pht_idx];
            if (upd.taken && c != 2'd3) begin
                c = c + 2'd1;
            end else if (!upd.taken && c != 2'd0) begin
                c = c - 2'd1;
            end
            m_pht[upd.pht_idx] = c;
        end
        if (flush_now) begin
            m_ghr = '0;
        end else if (cond) begin
            m_ghr = {m_ghr[3:0], upd.taken};
        end
        if (ctrl_we) begin
            m_enable = reg_wdata[0];
        end
        m_flush = ctrl_we && reg_wdata[1] && !flush_now;
        if (reg_we && reg_addr == 2'd2) begin
            m_ncond = 0;
        end else if (cond) begin
            m_ncond = m_ncond + 1;
        end
        if (reg_we && reg_addr == 2'd3) begin
            m_ntaken = 0;
        end else if (cond && upd.taken) begin
            m_ntaken = m_ntaken + 1;
        end
    endtask

    task automatic note_mismatch(string msg);
        n_errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    // compare every cycle once the outputs have settled
    always @(negedge clk) begin : compare
        pred_t exp_p;
        if (check_en) begin
            exp_p = ref_predict(lookup_pc);
            n_checks++;
            assert (predict_taken === exp_p.taken && predict_target === exp_p.target &&
                    pht_idx === exp_p.idx)
            else note_mismatch($sformatf("pc %h predicted %b %h idx %h, expected %b %h idx %h",
                lookup_pc, predict_taken, predict_target, pht_idx,
                exp_p.taken, exp_p.target, exp_p.idx));
            assert (reg_rdata === ref_read(reg_addr))
            else note_mismatch($sformatf("register %0d read %h, expected %h",
                reg_addr, reg_rdata, ref_read(reg_addr)));
        end
    end

    task automatic cycle(bp_pkg::addr_t pc, bp_pkg::bp_update_t u, logic we,
                         logic [1:0] addr, bp_pkg::reg_data_t wd);
        @(posedge clk);
        model_commit();
        lookup_pc <= pc;
        upd       <= u;
        reg_we    <= we;
        reg_addr  <= addr;
        reg_wdata <= wd;
    endtask

    function automatic bp_pkg::bp_update_t make_update(bp_pkg::addr_t pc, bp_pkg::addr_t tgt,
            bp_pkg::br_kind_t kind, logic taken, bp_pkg::pht_idx_t idx);
        bp_pkg::bp_update_t u;
        u.valid   = 1'b1;
        u.pc      = pc;
        u.target  = tgt;
        u.kind    = kind;
        u.taken   = taken;
        u.pht_idx = idx;
        return u;
    endfunction

    task automatic lookup(bp_pkg::addr_t pc);
        cycle(pc, '0, 1'b0, reg_addr, '0);
    endtask

    task automatic send_update(bp_pkg::bp_update_t u);
        cycle(lookup_pc, u, 1'b0, reg_addr, '0);
    endtask

    task automatic cond_update(bp_pkg::addr_t pc, logic taken, bp_pkg::pht_idx_t idx);
        send_update(make_update(pc, pc + 32'h100, bp_pkg::BR_COND, taken, idx));
    endtask

    // five not-taken outcomes on an unrelated counter bring the history back to zero
    task automatic clear_history();
        repeat (5) cond_update(PC_Q, 1'b0, Q_IDX);
    endtask

    task automatic write_reg(logic [1:0] addr, bp_pkg::reg_data_t wd);
        cycle(lookup_pc, '0, 1'b1, addr, wd);
    endtask

    task automatic read_reg(logic [1:0] addr, bp_pkg::reg_data_t exp_val);
        cycle(lookup_pc, '0, 1'b0, addr, '0);
        @(negedge clk);
        n_checks++;
        assert (reg_rdata === exp_val)
        else note_mismatch($sformatf("register %0d read %h, expected %h", addr, reg_rdata, exp_val));
    endtask

    task automatic check_pred(logic exp_taken, bp_pkg::addr_t exp_target);
        @(negedge clk);
        n_checks++;
        assert (predict_taken === exp_taken && predict_target === exp_target)
        else note_mismatch($sformatf("pc %h predicted %b %h, expected %b %h",
            lookup_pc, predict_taken, predict_target, exp_taken, exp_target));
    endtask

    task automatic finish_test(int num, string name);
        $display("test %0d %s finished, %0d errors so far", num, name, n_errors);
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not complete within %0d cycles",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        bp_pkg::addr_t      pool [8];
        bp_pkg::addr_t      pc;
        bp_pkg::addr_t      upc;
        bp_pkg::bp_update_t u;
        pred_t              p;
        logic               we;
        logic [1:0]         addr;
        int unsigned        n_cond;
        int unsigned        n_taken;
        void'($urandom(57897));
        arst_n_i  = 1'b0;
        lookup_pc = '0;
        upd       = '0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        check_en  = 1'b0;
        n_checks  = 0;
        n_errors  = 0;
        m_valid   = '0;
        m_jump    = '0;
        m_ghr     = '0;
        m_enable  = 1'b1;
        m_flush   = 1'b0;
        m_ncond   = 0;
        m_ntaken  = 0;
        for (int i = 0; i < 32; i++) begin
            m_pht[i] = bp_pkg::PHT_RESET;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        check_en = 1'b1;

        repeat (12) begin
            pc = $urandom & 32'hffff_fffc;
            lookup(pc);
            check_pred(1'b0, '0);
            assert (pht_idx === pc[6:2])
            else note_mismatch($sformatf("pht index %h for pc %h after reset", pht_idx, pc));
        end
        read_reg(bp_pkg::REG_GHR, '0);
        read_reg(bp_pkg::REG_NCOND, '0);
        read_reg(bp_pkg::REG_NTAKEN, '0);
        finish_test(1, "reset state");

        send_update(make_update(PC_A, 32'h2000, bp_pkg::BR_JUMP, 1'b1, '0));
        lookup(PC_A);
        check_pred(1'b1, 32'h2000);
        lookup(PC_B);
        check_pred(1'b0, '0);
        send_update(make_update(PC_A, 32'h3000, bp_pkg::BR_JUMP, 1'b1, '0));
        lookup(PC_A);
        check_pred(1'b1, 32'h3000);
        finish_test(2, "jump allocation");

        // the entry of PC_C is looked up with a zero history, so it reads counter P_IDX
        cond_update(PC_C, 1'b1, P_IDX);
        clear_history();
        lookup(PC_C);
        check_pred(1'b1, PC_C + 32'h100);
        cond_update(PC_C, 1'b1, P_IDX);
        cond_update(PC_C, 1'b1, P_IDX);
        read_reg(bp_pkg::REG_GHR, 32'd3);
        clear_history();
        cond_update(PC_C, 1'b0, P_IDX);
        lookup(PC_C);
        check_pred(1'b1, PC_C + 32'h100);
        cond_update(PC_C, 1'b0, P_IDX);
        lookup(PC_C);
        check_pred(1'b0, PC_C + 32'h100);
        cond_update(PC_C, 1'b0, P_IDX);
        cond_update(PC_C, 1'b0, P_IDX);
        cond_update(PC_C, 1'b1, P_IDX);
        clear_history();
        lookup(PC_C);
        check_pred(1'b0, PC_C + 32'h100);
        cond_update(PC_C, 1'b1, P_IDX);
        clear_history();
        lookup(PC_C);
        check_pred(1'b1, PC_C + 32'h100);
        finish_test(3, "counter training");

        cond_update(PC_Q, 1'b1, Q_IDX);
        read_reg(bp_pkg::REG_GHR, 32'd1);
        write_reg(bp_pkg::REG_CTRL, 32'd3);
        lookup(PC_A);
        lookup(PC_A);
        check_pred(1'b0, '0);
        lookup(PC_C);
        check_pred(1'b0, '0);
        read_reg(bp_pkg::REG_GHR, '0);
        // counter P_IDX must still hold its weakly-taken state
        cond_update(PC_C, 1'b1, Q_IDX);
        clear_history();
        lookup(PC_C);
        check_pred(1'b1, PC_C + 32'h100);
        write_reg(bp_pkg::REG_CTRL, 32'd0);
        lookup(PC_C);
        check_pred(1'b0, '0);
        read_reg(bp_pkg::REG_CTRL, '0);
        write_reg(bp_pkg::REG_CTRL, 32'd1);
        lookup(PC_C);
        check_pred(1'b1, PC_C + 32'h100);
        finish_test(4, "flush and enable");

        // four BTB indices, two tags each
        for (int i = 0; i < 8; i++) begin
            pool[i] = 32'h1000 + (i % 4) * 4 + (i / 4) * 32'h80;
        end
        n_cond  = m_ncond;
        n_taken = m_ntaken;
        for (int i = 0; i < 400; i++) begin
            pc = pool[$urandom_range(0, 7)];
            u  = '0;
            if ($urandom_range(0, 1) == 1) begin
                upc = pool[$urandom_range(0, 7)];
                p   = ref_predict(upc);
                u   = make_update(upc, $urandom & 32'hffff_fffc,
                                  bp_pkg::br_kind_t'($urandom_range(0, 2)),
                                  1'($urandom_range(0, 1)), p.idx);
                if (u.kind == bp_pkg::BR_COND) begin
                    n_cond++;
                    n_taken += u.taken;
                end
            end
            we   = ($urandom_range(0, 49) == 0);
            addr = we ? bp_pkg::REG_CTRL : 2'($urandom_range(0, 3));
            cycle(pc, u, we, addr, 32'd3);
        end
        lookup(pool[0]);
        read_reg(bp_pkg::REG_NCOND, n_cond);
        read_reg(bp_pkg::REG_NTAKEN, n_taken);
        finish_test(5, "random mix");

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== branch_predictor.f ====
hw/bp_pkg.sv
hw/bp_btb.sv
hw/bp_gshare.sv
hw/bp_regs.sv
hw/branch_predictor.sv
bench/tb_branch_predictor.sv

// ==== Bender.yml ====
package:
  name: branch_predictor

sources:
  - hw/bp_pkg.sv
  - hw/bp_btb.sv
  - hw/bp_gshare.sv
  - hw/bp_regs.sv
  - hw/branch_predictor.sv
  - target: test
    files:
      - bench/tb_branch_predictor.sv
